// File: mem_pkg.sv
`default_nettype none

package mem_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////
    localparam int xlen    = 32;   // data and address
    localparam int prf_len = 6;    // physical register tag
    localparam int rob_len = 5;    // reorder buffer index

    // one operand word holding either a finished value or the tag it waits for
    typedef union packed {
        logic [xlen-1:0] value;
        struct packed {
            logic [xlen-prf_len-1:0] pad;
            logic [prf_len-1:0]      tag;
        } phys;
    } operand_u;

    //////////////////////////////
    // station entries
    //////////////////////////////
    typedef struct packed {
        logic               base_ready;
        operand_u           base;
        logic               data_ready;
        operand_u           data;
        logic [xlen-1:0]    offset;
        logic [rob_len-1:0] rob_idx;
    } store_entry_t;

    typedef struct packed {
        logic               base_ready;
        operand_u           base;
        logic [xlen-1:0]    offset;
        logic [prf_len-1:0] dest_tag;
        logic [rob_len-1:0] rob_idx;
    } load_entry_t;

    // returns {ready, operand} after looking at both wakeup buses
    function automatic logic [xlen:0] snoop(
        input logic               ready,
        input operand_u           op,
        input logic               v0,
        input logic [prf_len-1:0] t0,
        input logic [xlen-1:0]    d0,
        input logic               v1,
        input logic [prf_len-1:0] t1,
        input logic [xlen-1:0]    d1
    );
        if (!ready && v0 && op.phys.tag == t0) return {1'b1, d0};
        if (!ready && v1 && op.phys.tag == t1) return {1'b1, d1};
        return {ready, op.value};
    endfunction

endpackage

`default_nettype wire

// File: rs_mem_if.sv
`timescale 1ns/1ps
`default_nettype none

// request and reply between one station and the arbiter
interface rs_mem_if;

    logic                     req;     // held until done
    logic [mem_pkg::xlen-1:0] addr;    // byte address
    logic [mem_pkg::xlen-1:0] wdata;   // only meaningful on the store port
    logic                     done;    // one cycle pulse
    logic [mem_pkg::xlen-1:0] rdata;

    modport station (
        output req,
        output addr,
        output wdata,
        input  done,
        input  rdata
    );

    modport arbiter (
        input  req,
        input  addr,
        input  wdata,
        output done,
        output rdata
    );

endinterface

`default_nettype wire

// File: apb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface apb_if;

    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [mem_pkg::xlen-1:0] paddr;    // byte address
    logic [mem_pkg::xlen-1:0] pwdata;
    logic [mem_pkg::xlen-1:0] prdata;
    logic                     pready;

    modport master (
        output psel,
        output penable,
        output pwrite,
        output paddr,
        output pwdata,
        input  prdata,
        input  pready
    );

    modport slave (
        input  psel,
        input  penable,
        input  pwrite,
        input  paddr,
        input  pwdata,
        output prdata,
        output pready
    );

endinterface

`default_nettype wire

// File: rs_store.sv
`timescale 1ns/1ps
`default_nettype none

module rs_store #(
    parameter int rs_depth = 4
) (
    input  wire                          clock,
    input  wire                          rst,
    input  wire                          flush,
    input  wire                          disp_valid,
    input  wire                          disp_base_ready,
    input  wire  [mem_pkg::xlen-1:0]     disp_base,
    input  wire                          disp_data_ready,
    input  wire  [mem_pkg::xlen-1:0]     disp_data,
    input  wire  [mem_pkg::xlen-1:0]     disp_offset,
    input  wire  [mem_pkg::rob_len-1:0]  disp_rob_idx,
    input  wire                          ext_cdb_valid,
    input  wire  [mem_pkg::prf_len-1:0]  ext_cdb_tag,
    input  wire  [mem_pkg::xlen-1:0]     ext_cdb_value,
    input  wire                          ld_valid,
    input  wire  [mem_pkg::prf_len-1:0]  ld_tag,
    input  wire  [mem_pkg::xlen-1:0]     ld_value,
    rs_mem_if.station                    mem,
    output logic                         st_done,
    output logic [mem_pkg::rob_len-1:0]  st_rob_idx,
    output logic                         full
);
    localparam int iw = (rs_depth > 1) ? $clog2(rs_depth) : 1;

    mem_pkg::store_entry_t [rs_depth-1:0] ent;
    mem_pkg::store_entry_t                new_ent;
    logic [rs_depth-1:0] valid;
    logic [iw-1:0]       free_idx;
    logic [iw-1:0]       sel_idx;
    logic [iw-1:0]       req_idx;   // entry owning the open request
    logic                any_ready;
    logic                finish;

    assign full   = &valid;
    assign finish = mem.req && mem.done;

    // lowest free slot and lowest entry with both operands
    always_comb begin
        free_idx  = '0;
        sel_idx   = '0;
        any_ready = 1'b0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!valid[i]) free_idx = iw'(i);
            if (valid[i] && ent[i].base_ready && ent[i].data_ready) begin
                sel_idx   = iw'(i);
                any_ready = 1'b1;
            end
        end
    end

    // a broadcast in the dispatch cycle is caught here
    always_comb begin
        new_ent.offset  = disp_offset;
        new_ent.rob_idx = disp_rob_idx;
        {new_ent.base_ready, new_ent.base} = mem_pkg::snoop(disp_base_ready, disp_base,
            ext_cdb_valid, ext_cdb_tag, ext_cdb_value, ld_valid, ld_tag, ld_value);
        {new_ent.data_ready, new_ent.data} = mem_pkg::snoop(disp_data_ready, disp_data,
            ext_cdb_valid, ext_cdb_tag, ext_cdb_value, ld_valid, ld_tag, ld_value);
    end

    //////////////////////////////
    // control
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (rst || flush) begin
            valid   <= '0;
            mem.req <= 1'b0;
            st_done <= 1'b0;
        end else begin
            st_done <= finish;
            if (finish) begin
                mem.req        <= 1'b0;
                valid[req_idx] <= 1'b0;   // freed with its done
            end else if (!mem.req && any_ready) begin
                mem.req <= 1'b1;
            end
            if (disp_valid && !full) valid[free_idx] <= 1'b1;
        end
    end

    //////////////////////////////
    // payload
    //////////////////////////////
    always_ff @(posedge clock) begin
        for (int i = 0; i < rs_depth; i++) begin
            {ent[i].base_ready, ent[i].base} <= mem_pkg::snoop(ent[i].base_ready, ent[i].base,
                ext_cdb_valid, ext_cdb_tag, ext_cdb_value, ld_valid, ld_tag, ld_value);
            {ent[i].data_ready, ent[i].data} <= mem_pkg::snoop(ent[i].data_ready, ent[i].data,
                ext_cdb_valid, ext_cdb_tag, ext_cdb_value, ld_valid, ld_tag, ld_value);
        end
        if (disp_valid && !full) ent[free_idx] <= new_ent;
        if (!mem.req && any_ready) begin
            req_idx   <= sel_idx;
            mem.addr  <= ent[sel_idx].base.value + ent[sel_idx].offset;
            mem.wdata <= ent[sel_idx].data.value;
        end
        if (finish) st_rob_idx <= ent[req_idx].rob_idx;
    end

endmodule

`default_nettype wire

// File: rs_load.sv
`timescale 1ns/1ps
`default_nettype none

module rs_load #(
    parameter int rs_depth = 4
) (
    input  wire                          clock,
    input  wire                          rst,
    input  wire                          flush,
    input  wire                          disp_valid,
    input  wire                          disp_base_ready,
    input  wire  [mem_pkg::xlen-1:0]     disp_base,
    input  wire  [mem_pkg::xlen-1:0]     disp_offset,
    input  wire  [mem_pkg::prf_len-1:0]  disp_dest_tag,
    input  wire  [mem_pkg::rob_len-1:0]  disp_rob_idx,
    input  wire                          ext_cdb_valid,
    input  wire  [mem_pkg::prf_len-1:0]  ext_cdb_tag,
    input  wire  [mem_pkg::xlen-1:0]     ext_cdb_value,
    rs_mem_if.station                    mem,
    output logic                         ld_valid,
    output logic [mem_pkg::prf_len-1:0]  ld_tag,
    output logic [mem_pkg::xlen-1:0]     ld_value,
    output logic                         full
);
    localparam int iw = (rs_depth > 1) ? $clog2(rs_depth) : 1;

    mem_pkg::load_entry_t [rs_depth-1:0] ent;
    mem_pkg::load_entry_t                new_ent;
    logic [rs_depth-1:0] valid;
    logic [iw-1:0]       free_idx;
    logic [iw-1:0]       sel_idx;
    logic [iw-1:0]       req_idx;
    logic                any_ready;
    logic                finish;

    assign full      = &valid;
    assign finish    = mem.req && mem.done;
    assign mem.wdata = '0;   // loads never write

    always_comb begin
        free_idx  = '0;
        sel_idx   = '0;
        any_ready = 1'b0;
        for (int i = rs_depth - 1; i >= 0; i--) begin
            if (!valid[i]) free_idx = iw'(i);
            if (valid[i] && ent[i].base_ready) begin
                sel_idx   = iw'(i);
                any_ready = 1'b1;
            end
        end
    end

    // own result bus wakes loads waiting on an earlier load
    always_comb begin
        new_ent.offset   = disp_offset;
        new_ent.dest_tag = disp_dest_tag;
        new_ent.rob_idx  = disp_rob_idx;
        {new_ent.base_ready, new_ent.base} = mem_pkg::snoop(disp_base_ready, disp_base,
            ext_cdb_valid, ext_cdb_tag, ext_cdb_value, ld_valid, ld_tag, ld_value);
    end

    //////////////////////////////
    // control
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (rst || flush) begin
            valid    <= '0;
            mem.req  <= 1'b0;
            ld_valid <= 1'b0;
        end else begin
            ld_valid <= finish;   // broadcast one cycle after done
            if (finish) begin
                mem.req        <= 1'b0;
                valid[req_idx] <= 1'b0;
            end else if (!mem.req && any_ready) begin
                mem.req <= 1'b1;
            end
            if (disp_valid && !full) valid[free_idx] <= 1'b1;
        end
    end

    //////////////////////////////
    // payload
    //////////////////////////////
    always_ff @(posedge clock) begin
        for (int i = 0; i < rs_depth; i++) begin
            {ent[i].base_ready, ent[i].base} <= mem_pkg::snoop(ent[i].base_ready, ent[i].base,
                ext_cdb_valid, ext_cdb_tag, ext_cdb_value, ld_valid, ld_tag, ld_value);
        end
        if (disp_valid && !full) ent[free_idx] <= new_ent;
        if (!mem.req && any_ready) begin
            req_idx  <= sel_idx;
            mem.addr <= ent[sel_idx].base.value + ent[sel_idx].offset;
        end
        if (finish) begin
            ld_tag   <= ent[req_idx].dest_tag;
            ld_value <= mem.rdata;
        end
    end

endmodule

`default_nettype wire

// File: mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input wire         clock,
    input wire         rst,
    rs_mem_if.arbiter  st_port,
    rs_mem_if.arbiter  ld_port,
    apb_if.master      apb
);
    localparam logic [1:0] idle   = 2'd0;
    localparam logic [1:0] setup  = 2'd1;
    localparam logic [1:0] access = 2'd2;

    logic [1:0] state;
    logic       prio;        // set: load port goes first
    logic       gnt_ld;      // current transfer belongs to the load port
    logic       dropped;     // owner let go of req, result is thrown away
    logic       pick_ld;
    logic       owner_req;
    logic       xfer_end;

    assign pick_ld   = ld_port.req && (!st_port.req || prio);
    assign owner_req = gnt_ld ? ld_port.req : st_port.req;
    assign xfer_end  = (state == access) && apb.pready && !dropped;

    assign apb.psel    = (state != idle);
    assign apb.penable = (state == access);

    // reply only to the owner of the transfer
    assign st_port.done  = xfer_end && !gnt_ld && st_port.req;
    assign ld_port.done  = xfer_end && gnt_ld && ld_port.req;
    assign st_port.rdata = gnt_ld ? '0 : apb.prdata;
    assign ld_port.rdata = gnt_ld ? apb.prdata : '0;

    //////////////////////////////
    // FSM
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (rst) begin
            state   <= idle;
            prio    <= 1'b0;
            dropped <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (st_port.req || ld_port.req) begin
                        state   <= setup;
                        prio    <= !pick_ld;   // other peer wins next time
                        dropped <= 1'b0;
                    end
                end
                setup:   state <= access;
                access:  if (apb.pready) state <= idle;
                default: state <= idle;
            endcase
            // a flushed station drops req mid transfer
            if (state != idle && !owner_req) dropped <= 1'b1;
        end
    end

    // address and data are captured at grant
    always_ff @(posedge clock) begin
        if (state == idle) begin
            gnt_ld     <= pick_ld;
            apb.pwrite <= !pick_ld;
            apb.paddr  <= pick_ld ? ld_port.addr : st_port.addr;
            apb.pwdata <= st_port.wdata;
        end
    end

endmodule

`default_nettype wire

// File: data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
    parameter int mem_words = 64
) (
    input wire     clock,
    input wire     rst,
    apb_if.slave   apb
);
    localparam int aw = (mem_words > 1) ? $clog2(mem_words) : 1;

    logic [mem_pkg::xlen-1:0] words [mem_words];
    logic [aw-1:0]            word_idx;
    logic                     first_access;

    // word address wrapped to the array size
    assign word_idx     = aw'(apb.paddr[mem_pkg::xlen-1:2] % mem_words);
    assign first_access = apb.psel && apb.penable && !apb.pready;

    // one wait state so pready comes in the second access cycle
    always_ff @(posedge clock) begin
        if (rst) begin
            apb.pready <= 1'b0;
        end else begin
            apb.pready <= first_access;
        end
    end

    //////////////////////////////
    // storage
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (first_access) begin
            apb.prdata <= words[word_idx];   // valid during the handshake
        end
        if (apb.psel && apb.penable && apb.pready && apb.pwrite) begin
            words[word_idx] <= apb.pwdata;
        end
    end

endmodule

`default_nettype wire

// File: mem_rs_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_rs_top #(
    parameter int rs_depth  = 4,
    parameter int mem_words = 64
) (
    input  wire                          clock,
    input  wire                          rst,
    input  wire                          flush,
    input  wire                          disp_valid,
    input  wire                          disp_is_store,
    input  wire                          disp_base_ready,
    input  wire  [mem_pkg::xlen-1:0]     disp_base,
    input  wire                          disp_data_ready,
    input  wire  [mem_pkg::xlen-1:0]     disp_data,
    input  wire  [mem_pkg::xlen-1:0]     disp_offset,
    input  wire  [mem_pkg::prf_len-1:0]  disp_dest_tag,
    input  wire  [mem_pkg::rob_len-1:0]  disp_rob_idx,
    input  wire                          ext_cdb_valid,
    input  wire  [mem_pkg::prf_len-1:0]  ext_cdb_tag,
    input  wire  [mem_pkg::xlen-1:0]     ext_cdb_value,
    output logic                         ld_valid,
    output logic [mem_pkg::prf_len-1:0]  ld_tag,
    output logic [mem_pkg::xlen-1:0]     ld_value,
    output logic                         st_done,
    output logic [mem_pkg::rob_len-1:0]  st_rob_idx,
    output logic                         st_full,
    output logic                         ld_full
);
    rs_mem_if st_mem ();
    rs_mem_if ld_mem ();
    apb_if    apb ();

    logic st_disp;
    logic ld_disp;

    assign st_disp = disp_valid && disp_is_store;
    assign ld_disp = disp_valid && !disp_is_store;

    //////////////////////////////
    // stations
    //////////////////////////////
    rs_store #(.rs_depth(rs_depth)) i_rs_store (
        .clock, .rst, .flush,
        .disp_valid      (st_disp),
        .disp_base_ready, .disp_base, .disp_data_ready, .disp_data,
        .disp_offset, .disp_rob_idx,
        .ext_cdb_valid, .ext_cdb_tag, .ext_cdb_value,
        .ld_valid, .ld_tag, .ld_value,   // load results wake stores too
        .mem             (st_mem),
        .st_done, .st_rob_idx,
        .full            (st_full)
    );

    rs_load #(.rs_depth(rs_depth)) i_rs_load (
        .clock, .rst, .flush,
        .disp_valid      (ld_disp),
        .disp_base_ready, .disp_base, .disp_offset, .disp_dest_tag, .disp_rob_idx,
        .ext_cdb_valid, .ext_cdb_tag, .ext_cdb_value,
        .mem             (ld_mem),
        .ld_valid, .ld_tag, .ld_value,
        .full            (ld_full)
    );

    //////////////////////////////
    // memory path
    //////////////////////////////
    mem_arbiter i_mem_arbiter (
        .clock, .rst,
        .st_port (st_mem),
        .ld_port (ld_mem),
        .apb     (apb)
    );

    data_mem #(.mem_words(mem_words)) i_data_mem (
        .clock, .rst,
        .apb (apb)
    );

endmodule

`default_nettype wire

// File: tb_mem_rs.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_rs;

    localparam int rs_depth  = 4;
    localparam int mem_words = 64;
    localparam int max_rec   = 64;
    localparam int rec_words = 8;    // op flags base data offset tag rob expect
    localparam int rob_n     = 1 << mem_pkg::rob_len;
    localparam int tag_n     = 1 << mem_pkg::prf_len;

    logic                         clock;
    logic                         rst;
    logic                         flush;
    logic                         disp_valid;
    logic                         disp_is_store;
    logic                         disp_base_ready;
    logic [mem_pkg::xlen-1:0]     disp_base;
    logic                         disp_data_ready;
    logic [mem_pkg::xlen-1:0]     disp_data;
    logic [mem_pkg::xlen-1:0]     disp_offset;
    logic [mem_pkg::prf_len-1:0]  disp_dest_tag;
    logic [mem_pkg::rob_len-1:0]  disp_rob_idx;
    logic                         ext_cdb_valid;
    logic [mem_pkg::prf_len-1:0]  ext_cdb_tag;
    logic [mem_pkg::xlen-1:0]     ext_cdb_value;
    logic                         ld_valid;
    logic [mem_pkg::prf_len-1:0]  ld_tag;
    logic [mem_pkg::xlen-1:0]     ld_value;
    logic                         st_done;
    logic [mem_pkg::rob_len-1:0]  st_rob_idx;
    logic                         st_full;
    logic                         ld_full;

    logic [31:0] pat [max_rec*rec_words];
    logic [31:0] f_op;
    logic [31:0] f_flags;
    logic [31:0] f_base;
    logic [31:0] f_data;
    logic [31:0] f_off;
    logic [31:0] f_tag;
    logic [31:0] f_rob;
    logic [31:0] f_exp;

    //////////////////////////////
    // reference model
    //////////////////////////////
    logic [31:0] mem_model [mem_words];
    logic        mem_known [mem_words];
    logic [31:0] prf_val [tag_n];        // values seen on either wakeup bus
    logic        prf_known [tag_n];
    logic        st_pend [rob_n];        // stores still owed an st_done
    logic        st_base_rdy [rob_n];
    logic [31:0] st_base [rob_n];
    logic        st_data_rdy [rob_n];
    logic [31:0] st_data [rob_n];
    logic [31:0] st_off [rob_n];
    logic        ld_pend [tag_n];        // loads by destination tag
    logic        ld_base_rdy [tag_n];
    logic [31:0] ld_base [tag_n];
    logic [31:0] ld_off [tag_n];
    logic [31:0] ld_exp [tag_n];

    int pending     = 0;
    int errors      = 0;
    int checks      = 0;
    int cycles      = 0;
    int cycle_limit = 0;
    int n_rec       = 0;
    int rec_idx     = 0;

    mem_rs_top #(.rs_depth(rs_depth), .mem_words(mem_words)) i_mem_rs_top (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the pattern records did not finish", cycles);
            $display("test failed");
            $finish;
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    function automatic int word_of(input logic [31:0] addr);
        return int'(addr[31:2]) % mem_words;
    endfunction

    // value of an operand once its tag was broadcast
    function automatic logic resolve(input logic rdy, input logic [31:0] op,
                                     output logic [31:0] val);
        if (rdy) begin
            val = op;
            return 1'b1;
        end
        val = prf_val[op[mem_pkg::prf_len-1:0]];
        return prf_known[op[mem_pkg::prf_len-1:0]];
    endfunction

    task automatic clear_pending();
        int i;
        for (i = 0; i < rob_n; i++) st_pend[i] = 1'b0;
        for (i = 0; i < tag_n; i++) ld_pend[i] = 1'b0;
        pending = 0;
    endtask

    task automatic init_model();
        int i;
        for (i = 0; i < mem_words; i++) mem_known[i] = 1'b0;
        for (i = 0; i < tag_n; i++) prf_known[i] = 1'b0;
        clear_pending();
    endtask

    // completions are sampled mid cycle
    task automatic observe();
        logic [31:0] base_v;
        logic [31:0] data_v;
        logic [31:0] exp_v;
        logic        ok_b;
        logic        ok_d;
        int          w;
        if (st_done) begin
            if (!st_pend[st_rob_idx]) begin
                errors++;
                $display("store done at %0t for rob index %0d, which was not waiting",
                         $time, st_rob_idx);
            end else begin
                ok_b = resolve(st_base_rdy[st_rob_idx], st_base[st_rob_idx], base_v);
                ok_d = resolve(st_data_rdy[st_rob_idx], st_data[st_rob_idx], data_v);
                if (!(ok_b && ok_d)) begin
                    errors++;
                    $display("store rob %0d finished before its operands were broadcast",
                             st_rob_idx);
                end
                w = word_of(base_v + st_off[st_rob_idx]);
                mem_model[w] = data_v;
                mem_known[w] = 1'b1;
                st_pend[st_rob_idx] = 1'b0;
                pending--;
            end
        end
        if (ld_valid) begin
            if (!ld_pend[ld_tag]) begin
                errors++;
                $display("load result at %0t for tag %0h, which was not waiting", $time, ld_tag);
            end else begin
                ok_b = resolve(ld_base_rdy[ld_tag], ld_base[ld_tag], base_v);
                if (!ok_b) begin
                    errors++;
                    $display("load tag %0h finished before its base was broadcast", ld_tag);
                end
                w = word_of(base_v + ld_off[ld_tag]);
                exp_v = mem_known[w] ? mem_model[w] : ld_exp[ld_tag];
                check_value(ld_value, exp_v, "ld_value");
                prf_val[ld_tag]   = exp_v;   // the load bus wakes later entries
                prf_known[ld_tag] = 1'b1;
                ld_pend[ld_tag]   = 1'b0;
                pending--;
            end
        end
    endtask

    task automatic next_cycle();
        @(negedge clock);
        observe();
        @(posedge clock);
        #1;
    endtask

    //////////////////////////////
    // record handlers
    //////////////////////////////
    task automatic dispatch_op(input logic is_store);
        logic [mem_pkg::prf_len-1:0] tag;
        logic [mem_pkg::rob_len-1:0] rob;
        logic                        dropped;
        tag     = f_tag[mem_pkg::prf_len-1:0];
        rob     = f_rob[mem_pkg::rob_len-1:0];
        dropped = f_flags[2];   // station expected full
        check_value({31'b0, is_store ? st_full : ld_full}, {31'b0, dropped}, "full at dispatch");
        disp_valid      = 1'b1;
        disp_is_store   = is_store;
        disp_base_ready = f_flags[0];
        disp_base       = f_base;
        disp_data_ready = f_flags[1];
        disp_data       = f_data;
        disp_offset     = f_off;
        disp_dest_tag   = tag;
        disp_rob_idx    = rob;
        if (!dropped && is_store) begin
            st_pend[rob]     = 1'b1;
            st_base_rdy[rob] = f_flags[0];
            st_base[rob]     = f_base;
            st_data_rdy[rob] = f_flags[1];
            st_data[rob]     = f_data;
            st_off[rob]      = f_off;
            pending++;
        end else if (!dropped) begin
            ld_pend[tag]     = 1'b1;
            ld_base_rdy[tag] = f_flags[0];
            ld_base[tag]     = f_base;
            ld_off[tag]      = f_off;
            ld_exp[tag]      = f_exp;
            pending++;
        end
        next_cycle();
        disp_valid = 1'b0;
    endtask

    task automatic run_record(input int r);
        case (f_op)
            32'd1: dispatch_op(1'b1);
            32'd2: dispatch_op(1'b0);
            32'd3: begin
                ext_cdb_valid = 1'b1;
                ext_cdb_tag   = f_tag[mem_pkg::prf_len-1:0];
                ext_cdb_value = f_data;
                prf_val[f_tag[mem_pkg::prf_len-1:0]]   = f_data;
                prf_known[f_tag[mem_pkg::prf_len-1:0]] = 1'b1;
                next_cycle();
                ext_cdb_valid = 1'b0;
            end
            32'd4: begin
                flush = 1'b1;
                clear_pending();   // flushed entries never complete
                next_cycle();
                flush = 1'b0;
            end
            32'd5: begin
                while (pending > 0) next_cycle();
                repeat (f_base) next_cycle();   // quiet window
            end
            32'd6: begin
                check_value({31'b0, st_full}, f_base, "st_full");
                check_value({31'b0, ld_full}, f_data, "ld_full");
            end
            32'd7: repeat (f_base) next_cycle();
            default: begin
                errors++;
                $display("pattern record %0d has an unknown opcode %0h", r, f_op);
            end
        endcase
    endtask

    initial begin
        rst             = 1'b1;
        flush           = 1'b0;
        disp_valid      = 1'b0;
        disp_is_store   = 1'b0;
        disp_base_ready = 1'b0;
        disp_base       = '0;
        disp_data_ready = 1'b0;
        disp_data       = '0;
        disp_offset     = '0;
        disp_dest_tag   = '0;
        disp_rob_idx    = '0;
        ext_cdb_valid   = 1'b0;
        ext_cdb_tag     = '0;
        ext_cdb_value   = '0;
        init_model();
        $readmemh("mem_rs_patterns.txt", pat);
        while (n_rec < max_rec && pat[n_rec*rec_words] != 32'd0) n_rec++;
        if (n_rec == 0) begin
            errors++;
            $display("no pattern records were read");
        end
        cycle_limit = 40 * (n_rec + 1);
        repeat (2) @(posedge clock);
        #1;
        rst = 1'b0;
        for (rec_idx = 0; rec_idx < n_rec; rec_idx++) begin
            f_op    = pat[rec_idx*rec_words];
            f_flags = pat[rec_idx*rec_words+1];
            f_base  = pat[rec_idx*rec_words+2];
            f_data  = pat[rec_idx*rec_words+3];
            f_off   = pat[rec_idx*rec_words+4];
            f_tag   = pat[rec_idx*rec_words+5];
            f_rob   = pat[rec_idx*rec_words+6];
            f_exp   = pat[rec_idx*rec_words+7];
            run_record(rec_idx);
        end
        $display("records: %0d, checks: %0d, errors: %0d", n_rec, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: mem_rs_patterns.txt
// columns: op flags base data offset tag rob expect, hex; flags bit0 base ready, bit1 data
// ready, bit2 full so dropped; op 1 store 2 load 3 wakeup 4 flush 5 idle 6 full 7 delay 0 end
// store then load of the same word
1 3 00000100 cafe0001 00000008 00 01 00000000
5 0 00000004 00000000 00000000 00 00 00000000
2 1 00000100 00000000 00000008 10 02 00000000
5 0 00000004 00000000 00000000 00 00 00000000
// base tags woken by the external bus
1 2 00000021 cafe0002 00000010 00 03 00000000
7 0 0000000a 00000000 00000000 00 00 00000000
3 0 00000000 00000040 00000000 21 00 00000000
5 0 00000004 00000000 00000000 00 00 00000000
2 0 00000022 00000000 00000010 11 04 00000000
7 0 0000000a 00000000 00000000 00 00 00000000
3 0 00000000 00000040 00000000 22 00 00000000
5 0 00000004 00000000 00000000 00 00 00000000
// second load takes its base from the first load
1 3 00000000 00000060 00000020 00 05 00000000
1 3 00000060 beef0003 00000004 00 06 00000000
5 0 00000004 00000000 00000000 00 00 00000000
2 1 00000020 00000000 00000000 12 07 00000000
2 0 00000012 00000000 00000004 13 08 00000000
5 0 00000004 00000000 00000000 00 00 00000000
// fill the store station, fifth dispatch is dropped
1 2 00000030 11110000 00000000 00 09 00000000
1 2 00000030 11110001 00000004 00 0a 00000000
1 2 00000030 11110002 00000008 00 0b 00000000
1 2 00000030 11110003 0000000c 00 0c 00000000
1 6 00000030 11110004 00000010 00 0d 00000000
6 0 00000001 00000000 00000000 00 00 00000000
3 0 00000000 00000080 00000000 30 00 00000000
5 0 00000010 00000000 00000000 00 00 00000000
6 0 00000000 00000000 00000000 00 00 00000000
// flush waiting entries, late wakeup must not complete them
1 2 00000031 22220000 00000000 00 0e 00000000
1 2 00000031 22220001 00000004 00 0f 00000000
2 0 00000031 00000000 00000000 14 10 00000000
4 0 00000000 00000000 00000000 00 00 00000000
6 0 00000000 00000000 00000000 00 00 00000000
3 0 00000000 00000090 00000000 31 00 00000000
5 0 00000010 00000000 00000000 00 00 00000000
// ready store and ready load compete for the bus
1 3 000000a0 5a5a0006 00000000 00 11 00000000
2 1 00000100 00000000 00000008 15 12 00000000
5 0 00000004 00000000 00000000 00 00 00000000
0 0 00000000 00000000 00000000 00 00 00000000

// File: sources.f
mem_pkg.sv
rs_mem_if.sv
apb_if.sv
rs_store.sv
rs_load.sv
mem_arbiter.sv
data_mem.sv
mem_rs_top.sv
tb_mem_rs.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --timescale 1ns/1ps -f sources.f \
    --top-module tb_mem_rs -o tb_mem_rs
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_mem_rs > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$log"; then
    exit 1
fi
exit 0
